// File: Makefile
# Verilator flow for the reorder buffer testbench
# override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASS

SOURCES := $(wildcard rtl/*.sv tests/*.sv include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/rob_settings.svh
// sizing macros for the reorder buffer
// included by the package and by every block that needs the depth

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// number of buffer entries
`define ROB_DEPTH 16

// architectural register file size
`define ROB_ARCH_REGS 32

// physical register file size
`define ROB_PHYS_REGS 64

// result width
`define ROB_XLEN 32

`endif

// File: list.f
+incdir+include
rtl/rob_pkg.sv
rtl/rob_ctrl_if.sv
rtl/rob_pointers.sv
rtl/rob_storage.sv
rtl/rob_squash_scan.sv
rtl/rob_retire.sv
rtl/rob_top.sv
tests/rob_assert.sv
tests/rob_tb.sv

// File: rtl/rob_ctrl_if.sv
// control bundle between the pointer, storage, squash and retire blocks
// no clock of its own, every signal has exactly one driving block

`include "rob_settings.svh"

interface rob_ctrl_if import rob_pkg::*; ();

    // pointer state, owned by rob_pointers
    rob_idx_t   head_idx;
    rob_idx_t   tail_idx;
    rob_cnt_t   count;

    // per-cycle enables, already qualified by full and mispredict
    logic       alloc_en;
    logic       retire_en;
    logic       squash_en;
    rob_idx_t   squash_idx;

    // full entry array, owned by rob_storage
    rob_entry_t entries [`ROB_DEPTH];

    // squash scan results
    rob_mask_t  squash_mask;
    rob_cnt_t   squash_count;

    // head is ready to leave
    logic       retire_req;

    modport pointers (
        output head_idx, tail_idx, count,
        output alloc_en, retire_en, squash_en, squash_idx,
        input  squash_count, retire_req
    );

    modport storage (
        input  head_idx, tail_idx, alloc_en, retire_en, squash_en, squash_mask,
        output entries
    );

    modport scan (
        input  tail_idx, squash_en, squash_idx, entries,
        output squash_mask, squash_count
    );

    modport retire (
        input  head_idx, count, retire_en, entries,
        output retire_req
    );

endinterface

// File: rtl/rob_pkg.sv
// shared types for the reorder buffer
// blocks take these through a wildcard import in the module header

`include "rob_settings.svh"

package rob_pkg;

    // entry index and occupancy
    typedef logic [$clog2(`ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_cnt_t;

    // register names and result value
    typedef logic [$clog2(`ROB_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`ROB_PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [`ROB_XLEN-1:0]              rob_data_t;

    // one bit per physical register / per entry
    typedef logic [`ROB_PHYS_REGS-1:0] phys_mask_t;
    typedef logic [`ROB_DEPTH-1:0]     rob_mask_t;

    // one buffer slot as seen by the other blocks
    typedef struct packed {
        logic      valid;
        logic      done;
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
        rob_data_t value;
    } rob_entry_t;

    // what the pointers do in one cycle
    typedef enum logic [2:0] {
        PTR_HOLD,
        PTR_ALLOC,
        PTR_RETIRE,
        PTR_ALLOC_RETIRE,
        PTR_SQUASH
    } rob_ptr_op_t;

    // circular step to the next slot
    function automatic rob_idx_t rob_idx_inc(input rob_idx_t idx);
        if (idx == rob_idx_t'(`ROB_DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

endpackage

// File: rtl/rob_pointers.sv
// head, tail and occupancy of the reorder buffer
// picks one pointer opcode per cycle and hands out the qualified enables

`include "rob_settings.svh"

module rob_pointers import rob_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                disp_valid_i,
    input  logic                mispredict_i,
    input  rob_idx_t            mispredict_rob_idx_i,
    output logic                disp_ready_o,
    output rob_cnt_t            disp_space_o,
    rob_ctrl_if.pointers        ctrl
);

    rob_ptr_op_t op;
    rob_idx_t    head_q;
    rob_idx_t    tail_q;
    rob_idx_t    head_nxt;
    rob_idx_t    tail_nxt;
    rob_cnt_t    count_q;
    rob_cnt_t    count_nxt;
    rob_cnt_t    space_q;
    logic        full;
    logic        accept;

    // ====================
    // dispatch acceptance
    // ====================
    assign full         = (count_q == rob_cnt_t'(`ROB_DEPTH));
    // no new entries while a squash rewinds the tail
    assign disp_ready_o = !full && !mispredict_i;
    assign accept       = disp_valid_i && disp_ready_o;

    // squash wins over everything, retire is frozen with it
    always_comb begin
        if (mispredict_i) begin
            op = PTR_SQUASH;
        end else if (accept && ctrl.retire_req) begin
            op = PTR_ALLOC_RETIRE;
        end else if (accept) begin
            op = PTR_ALLOC;
        end else if (ctrl.retire_req) begin
            op = PTR_RETIRE;
        end else begin
            op = PTR_HOLD;
        end
    end

    // ====================
    // next pointer state
    // ====================
    always_comb begin
        head_nxt  = head_q;
        tail_nxt  = tail_q;
        count_nxt = count_q;
        case (op)
            PTR_ALLOC: begin
                tail_nxt  = rob_idx_inc(tail_q);
                count_nxt = count_q + 1'b1;
            end
            PTR_RETIRE: begin
                head_nxt  = rob_idx_inc(head_q);
                count_nxt = count_q - 1'b1;
            end
            PTR_ALLOC_RETIRE: begin
                // one in, one out, count unchanged
                tail_nxt = rob_idx_inc(tail_q);
                head_nxt = rob_idx_inc(head_q);
            end
            PTR_SQUASH: begin
                // branch survives, tail lands just past it
                tail_nxt  = rob_idx_inc(mispredict_rob_idx_i);
                count_nxt = count_q - ctrl.squash_count;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            space_q <= rob_cnt_t'(`ROB_DEPTH);
        end else begin
            head_q  <= head_nxt;
            tail_q  <= tail_nxt;
            count_q <= count_nxt;
            space_q <= rob_cnt_t'(`ROB_DEPTH) - count_nxt;
        end
    end

    assign disp_space_o    = space_q;

    // enables follow the opcode only
    assign ctrl.alloc_en   = (op == PTR_ALLOC) || (op == PTR_ALLOC_RETIRE);
    assign ctrl.retire_en  = (op == PTR_RETIRE) || (op == PTR_ALLOC_RETIRE);
    assign ctrl.squash_en  = (op == PTR_SQUASH);
    assign ctrl.squash_idx = mispredict_rob_idx_i;
    assign ctrl.head_idx   = head_q;
    assign ctrl.tail_idx   = tail_q;
    assign ctrl.count      = count_q;

endmodule

// File: rtl/rob_retire.sv
// in-order retirement of the head entry
// commit outputs are registered and last one cycle per retire

module rob_retire import rob_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    output logic                commit_valid_o,
    output logic                commit_rd_wen_o,
    output arch_reg_t           commit_rd_arch_o,
    output phys_reg_t           commit_new_prf_o,
    output phys_reg_t           commit_old_prf_o,
    output rob_data_t           commit_value_o,
    rob_ctrl_if.retire          ctrl
);

    rob_entry_t head_entry;

    assign head_entry = ctrl.entries[ctrl.head_idx];

    // head ready once written back, pointers decide if it may go
    assign ctrl.retire_req = (ctrl.count != '0) && head_entry.done;

    // ====================
    // commit port
    // ====================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= ctrl.retire_en;
        end
    end

    // fields only looked at while commit_valid_o is high
    always_ff @(posedge clock) begin
        if (ctrl.retire_en) begin
            commit_rd_wen_o  <= head_entry.rd_wen;
            commit_rd_arch_o <= head_entry.rd_arch;
            commit_new_prf_o <= head_entry.new_prf;
            commit_old_prf_o <= head_entry.old_prf;
            commit_value_o   <= head_entry.value;
        end
    end

endmodule

// File: rtl/rob_squash_scan.sv
// finds the entries younger than a mispredicted branch
// squash mask and count go back combinationally, freed registers are registered

`include "rob_settings.svh"

module rob_squash_scan import rob_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    output logic                free_valid_o,
    output phys_mask_t          free_regs_o,
    rob_ctrl_if.scan            ctrl
);

    phys_mask_t free_nxt;
    phys_mask_t free_regs_q;
    logic       free_valid_q;

    // ====================
    // walk branch+1 .. tail
    // ====================
    always_comb begin
        rob_idx_t   idx;
        logic       at_tail;
        rob_mask_t  mask;
        rob_cnt_t   cnt;
        phys_mask_t freed;
        idx     = rob_idx_inc(ctrl.squash_idx);
        at_tail = 1'b0;
        mask    = '0;
        cnt     = '0;
        freed   = '0;
        // at most depth-1 younger slots behind the branch
        for (int j = 0; j < `ROB_DEPTH - 1; j++) begin
            if (idx == ctrl.tail_idx) begin
                at_tail = 1'b1;
            end
            if (!at_tail && ctrl.entries[idx].valid) begin
                mask[idx] = 1'b1;
                cnt       = cnt + 1'b1;
                // new mapping of a squashed writer goes back to the free list
                if (ctrl.entries[idx].rd_wen) begin
                    freed[ctrl.entries[idx].new_prf] = 1'b1;
                end
            end
            idx = rob_idx_inc(idx);
        end
        ctrl.squash_mask  = mask;
        ctrl.squash_count = cnt;
        free_nxt          = freed;
    end

    // one-cycle pulse after the squash edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            free_regs_q  <= '0;
            free_valid_q <= 1'b0;
        end else begin
            free_regs_q  <= ctrl.squash_en ? free_nxt : '0;
            free_valid_q <= ctrl.squash_en && (|free_nxt);
        end
    end

    assign free_regs_o  = free_regs_q;
    assign free_valid_o = free_valid_q;

endmodule

// File: rtl/rob_storage.sv
// entry array of the reorder buffer
// allocate at tail, writeback by index, clear at head or by squash mask

`include "rob_settings.svh"

module rob_storage import rob_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                disp_rd_wen_i,
    input  arch_reg_t           disp_rd_arch_i,
    input  phys_reg_t           disp_new_prf_i,
    input  phys_reg_t           disp_old_prf_i,
    input  logic                wb_valid_i,
    input  rob_idx_t            wb_rob_idx_i,
    input  rob_data_t           wb_value_i,
    rob_ctrl_if.storage         ctrl
);

    // status bits
    rob_mask_t valid_q;
    rob_mask_t done_q;

    // payload
    logic      rd_wen_q  [`ROB_DEPTH];
    arch_reg_t rd_arch_q [`ROB_DEPTH];
    phys_reg_t new_prf_q [`ROB_DEPTH];
    phys_reg_t old_prf_q [`ROB_DEPTH];
    rob_data_t value_q   [`ROB_DEPTH];

    logic      wb_ok;

    // writeback into an entry that squash is killing is dropped
    assign wb_ok = wb_valid_i && !(ctrl.squash_en && ctrl.squash_mask[wb_rob_idx_i]);

    // ====================
    // status updates
    // ====================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            // fresh entry starts not done
            if (ctrl.alloc_en) begin
                valid_q[ctrl.tail_idx] <= 1'b1;
                done_q[ctrl.tail_idx]  <= 1'b0;
            end
            // mask clear comes first so a survivor's writeback still lands
            if (ctrl.squash_en) begin
                valid_q <= valid_q & ~ctrl.squash_mask;
                done_q  <= done_q & ~ctrl.squash_mask;
            end
            if (wb_ok) begin
                done_q[wb_rob_idx_i] <= 1'b1;
            end
            if (ctrl.retire_en) begin
                valid_q[ctrl.head_idx] <= 1'b0;
                done_q[ctrl.head_idx]  <= 1'b0;
            end
        end
    end

    // payload, only meaningful while valid
    always_ff @(posedge clock) begin
        if (ctrl.alloc_en) begin
            rd_wen_q[ctrl.tail_idx]  <= disp_rd_wen_i;
            rd_arch_q[ctrl.tail_idx] <= disp_rd_arch_i;
            new_prf_q[ctrl.tail_idx] <= disp_new_prf_i;
            old_prf_q[ctrl.tail_idx] <= disp_old_prf_i;
        end
        if (wb_ok) begin
            value_q[wb_rob_idx_i] <= wb_value_i;
        end
    end

    // repack for the readers
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            ctrl.entries[i] = '{valid: valid_q[i], done: done_q[i], rd_wen: rd_wen_q[i],
                                rd_arch: rd_arch_q[i], new_prf: new_prf_q[i],
                                old_prf: old_prf_q[i], value: value_q[i]};
        end
    end

endmodule

// File: rtl/rob_top.sv
// reorder buffer top level, single dispatch, writeback and commit per cycle
// plain ports outside, the four blocks share one control interface inside

module rob_top import rob_pkg::*; (
    input  logic       clock,
    input  logic       reset,

    // dispatch
    input  logic       disp_valid_i,
    input  logic       disp_rd_wen_i,
    input  arch_reg_t  disp_rd_arch_i,
    input  phys_reg_t  disp_new_prf_i,
    input  phys_reg_t  disp_old_prf_i,
    output logic       disp_ready_o,
    output logic       disp_alloc_o,
    output rob_idx_t   disp_rob_idx_o,
    output rob_cnt_t   disp_space_o,

    // writeback
    input  logic       wb_valid_i,
    input  rob_idx_t   wb_rob_idx_i,
    input  rob_data_t  wb_value_i,

    // branch mispredict
    input  logic       mispredict_i,
    input  rob_idx_t   mispredict_rob_idx_i,

    // commit
    output logic       commit_valid_o,
    output logic       commit_rd_wen_o,
    output arch_reg_t  commit_rd_arch_o,
    output phys_reg_t  commit_new_prf_o,
    output phys_reg_t  commit_old_prf_o,
    output rob_data_t  commit_value_o,

    // registers freed by squash
    output logic       free_valid_o,
    output phys_mask_t free_regs_o
);

    rob_ctrl_if ctrl ();

    // ====================
    // blocks
    // ====================
    rob_pointers u_pointers (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid_i),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .disp_ready_o         (disp_ready_o),
        .disp_space_o         (disp_space_o),
        .ctrl                 (ctrl.pointers)
    );

    rob_storage u_storage (
        .clock          (clock),
        .reset          (reset),
        .disp_rd_wen_i  (disp_rd_wen_i),
        .disp_rd_arch_i (disp_rd_arch_i),
        .disp_new_prf_i (disp_new_prf_i),
        .disp_old_prf_i (disp_old_prf_i),
        .wb_valid_i     (wb_valid_i),
        .wb_rob_idx_i   (wb_rob_idx_i),
        .wb_value_i     (wb_value_i),
        .ctrl           (ctrl.storage)
    );

    rob_squash_scan u_squash_scan (
        .clock        (clock),
        .reset        (reset),
        .free_valid_o (free_valid_o),
        .free_regs_o  (free_regs_o),
        .ctrl         (ctrl.scan)
    );

    rob_retire u_retire (
        .clock            (clock),
        .reset            (reset),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o),
        .commit_value_o   (commit_value_o),
        .ctrl             (ctrl.retire)
    );

    // acceptance and slot of this cycle's dispatch
    assign disp_alloc_o   = ctrl.alloc_en;
    assign disp_rob_idx_o = ctrl.tail_idx;

endmodule

// File: tests/rob_assert.sv
// protocol assertions for the reorder buffer top level
// bound into rob_top, watches the dispatch port and the squash side effects

`include "rob_settings.svh"

module rob_assert import rob_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     disp_alloc_o,
    input logic     disp_ready_o,
    input rob_cnt_t disp_space_o,
    input logic     free_valid_o,
    input logic     mispredict_i,
    input logic     commit_valid_o
);

    // ====================
    // dispatch port
    // ====================
    a_alloc_ready: assert property (@(posedge clock) disable iff (reset)
        disp_alloc_o |-> disp_ready_o)
        else $error("disp_alloc_o without disp_ready_o");

    a_space_range: assert property (@(posedge clock) disable iff (reset)
        disp_space_o <= rob_cnt_t'(`ROB_DEPTH))
        else $error("disp_space_o above depth");

    // ====================
    // squash side effects
    // ====================
    // freed registers only right after a mispredict edge
    a_free_after_squash: assert property (@(posedge clock) disable iff (reset)
        free_valid_o |-> $past(mispredict_i))
        else $error("free_valid_o without a mispredict the cycle before");

    // retire is frozen on the squash edge
    a_no_commit_after_squash: assert property (@(posedge clock) disable iff (reset)
        mispredict_i |=> !commit_valid_o)
        else $error("commit_valid_o right after a squash edge");

endmodule

bind rob_top rob_assert u_assert (
    .clock          (clock),
    .reset          (reset),
    .disp_alloc_o   (disp_alloc_o),
    .disp_ready_o   (disp_ready_o),
    .disp_space_o   (disp_space_o),
    .free_valid_o   (free_valid_o),
    .mispredict_i   (mispredict_i),
    .commit_valid_o (commit_valid_o)
);

// File: tests/rob_tb.sv
// directed testbench for the reorder buffer top level
// a queue model of in-flight entries checks every commit as it appears
// each test drives the dut through tasks that return at one unit past a rising edge

`include "rob_settings.svh"

module rob_tb import rob_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic       clock;
    logic       reset;
    logic       disp_valid_i;
    logic       disp_rd_wen_i;
    arch_reg_t  disp_rd_arch_i;
    phys_reg_t  disp_new_prf_i;
    phys_reg_t  disp_old_prf_i;
    logic       disp_ready_o;
    logic       disp_alloc_o;
    rob_idx_t   disp_rob_idx_o;
    rob_cnt_t   disp_space_o;
    logic       wb_valid_i;
    rob_idx_t   wb_rob_idx_i;
    rob_data_t  wb_value_i;
    logic       mispredict_i;
    rob_idx_t   mispredict_rob_idx_i;
    logic       commit_valid_o;
    logic       commit_rd_wen_o;
    arch_reg_t  commit_rd_arch_o;
    phys_reg_t  commit_new_prf_o;
    phys_reg_t  commit_old_prf_o;
    rob_data_t  commit_value_o;
    logic       free_valid_o;
    phys_mask_t free_regs_o;

    // expected in-flight entries, oldest first, with their slots
    rob_entry_t model_q [$];
    rob_idx_t   idx_q [$];

    // what the last negedge saw on the dispatch port
    logic       alloc_seen;
    rob_idx_t   idx_seen;

    // slot the next accepted dispatch should land in
    rob_idx_t   exp_tail;

    string      test_name;
    int         errors;
    int         err_mark;
    int         tests_run;
    int         commit_total;

    rob_top dut (
        .clock(clock), .reset(reset),
        .disp_valid_i(disp_valid_i), .disp_rd_wen_i(disp_rd_wen_i),
        .disp_rd_arch_i(disp_rd_arch_i), .disp_new_prf_i(disp_new_prf_i),
        .disp_old_prf_i(disp_old_prf_i), .disp_ready_o(disp_ready_o),
        .disp_alloc_o(disp_alloc_o), .disp_rob_idx_o(disp_rob_idx_o),
        .disp_space_o(disp_space_o), .wb_valid_i(wb_valid_i),
        .wb_rob_idx_i(wb_rob_idx_i), .wb_value_i(wb_value_i),
        .mispredict_i(mispredict_i), .mispredict_rob_idx_i(mispredict_rob_idx_i),
        .commit_valid_o(commit_valid_o), .commit_rd_wen_o(commit_rd_wen_o),
        .commit_rd_arch_o(commit_rd_arch_o), .commit_new_prf_o(commit_new_prf_o),
        .commit_old_prf_o(commit_old_prf_o), .commit_value_o(commit_value_o),
        .free_valid_o(free_valid_o), .free_regs_o(free_regs_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ====================
    // compare tasks
    // ====================
    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic check_idx(input string what, input rob_idx_t exp, input rob_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_cnt(input string what, input rob_cnt_t exp, input rob_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_mask(input string what, input phys_mask_t exp, input phys_mask_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_commit(input rob_entry_t exp);
        rob_entry_t act;
        act = '{valid: 1'b1, done: 1'b1, rd_wen: commit_rd_wen_o, rd_arch: commit_rd_arch_o,
                new_prf: commit_new_prf_o, old_prf: commit_old_prf_o, value: commit_value_o};
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s commit: expected %h actual %h", test_name, exp, act);
        end
    endtask

    // ====================
    // model and drivers
    // ====================
    function automatic int find_pos(input rob_idx_t idx);
        int pos;
        pos = -1;
        foreach (idx_q[i]) begin
            if (idx_q[i] == idx) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // one clock: observe at negedge, return just past the next rising edge
    task automatic cycle();
        rob_entry_t e;
        @(negedge clock);
        alloc_seen = disp_alloc_o;
        idx_seen   = disp_rob_idx_o;
        // older commit checked before this cycle's push
        if (commit_valid_o) begin
            if (model_q.size() == 0) begin
                errors++;
                $display("commit seen in test %s with no entry in flight", test_name);
            end else begin
                check_commit(model_q[0]);
                void'(model_q.pop_front());
                void'(idx_q.pop_front());
            end
            commit_total++;
        end
        if (alloc_seen) begin
            check_idx("disp_rob_idx_o", exp_tail, idx_seen);
            exp_tail = rob_idx_t'((int'(exp_tail) + 1) % `ROB_DEPTH);
            e = '{valid: 1'b1, done: 1'b0, rd_wen: disp_rd_wen_i, rd_arch: disp_rd_arch_i,
                  new_prf: disp_new_prf_i, old_prf: disp_old_prf_i, value: '0};
            model_q.push_back(e);
            idx_q.push_back(idx_seen);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic dispatch(input logic wen, input arch_reg_t rd, input phys_reg_t new_prf,
                            input phys_reg_t old_prf, output rob_idx_t idx);
        int n;
        n = 0;
        disp_valid_i   = 1'b1;
        disp_rd_wen_i  = wen;
        disp_rd_arch_i = rd;
        disp_new_prf_i = new_prf;
        disp_old_prf_i = old_prf;
        do begin
            cycle();
            n++;
        end while (!alloc_seen && n < TIMEOUT);
        disp_valid_i = 1'b0;
        idx = idx_seen;
        if (!alloc_seen) begin
            errors++;
            $display("dispatch in test %s was never accepted", test_name);
        end
    endtask

    task automatic writeback(input rob_idx_t idx, input rob_data_t value);
        rob_entry_t e;
        int pos;
        pos = find_pos(idx);
        if (pos < 0) begin
            errors++;
            $display("writeback to entry %0d that is not in flight", idx);
        end else begin
            e = model_q[pos];
            e.done  = 1'b1;
            e.value = value;
            model_q[pos] = e;
        end
        wb_valid_i   = 1'b1;
        wb_rob_idx_i = idx;
        wb_value_i   = value;
        cycle();
        wb_valid_i = 1'b0;
    endtask

    // younger writers give back their new mapping, the branch stays
    task automatic mispredict(input rob_idx_t idx, output phys_mask_t freed);
        int pos;
        pos   = find_pos(idx);
        freed = '0;
        if (pos < 0) begin
            errors++;
            $display("mispredict on entry %0d that is not in flight", idx);
        end else begin
            for (int i = pos + 1; i < model_q.size(); i++) begin
                if (model_q[i].rd_wen) begin
                    freed[model_q[i].new_prf] = 1'b1;
                end
            end
            while (model_q.size() > pos + 1) begin
                void'(model_q.pop_back());
                void'(idx_q.pop_back());
            end
            // tail rewinds to the slot after the branch
            exp_tail = rob_idx_t'((int'(idx) + 1) % `ROB_DEPTH);
        end
        mispredict_i         = 1'b1;
        mispredict_rob_idx_i = idx;
        cycle();
        mispredict_i = 1'b0;
    endtask

    task automatic wait_commits(input int target);
        int n;
        n = 0;
        while (commit_total < target && n < TIMEOUT) begin
            cycle();
            n++;
        end
        if (commit_total < target) begin
            errors++;
            $display("timed out in test %s waiting for commit %0d", test_name, target);
        end
    endtask

    // write back everything still pending and wait for the buffer to empty
    task automatic drain();
        rob_idx_t pending [$];
        int n;
        foreach (model_q[i]) begin
            if (!model_q[i].done) begin
                pending.push_back(idx_q[i]);
            end
        end
        foreach (pending[i]) begin
            writeback(pending[i], rob_data_t'($urandom()));
        end
        n = 0;
        while (model_q.size() > 0 && n < TIMEOUT) begin
            cycle();
            n++;
        end
        if (model_q.size() > 0) begin
            errors++;
            $display("drain in test %s timed out, %0d entries left", test_name, model_q.size());
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - err_mark);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset();
        start_test("reset");
        check_flag("disp_ready_o", 1'b1, disp_ready_o);
        check_cnt("disp_space_o", rob_cnt_t'(`ROB_DEPTH), disp_space_o);
        check_flag("commit_valid_o", 1'b0, commit_valid_o);
        check_flag("free_valid_o", 1'b0, free_valid_o);
        check_flag("disp_alloc_o", 1'b0, disp_alloc_o);
        check_mask("free_regs_o", '0, free_regs_o);
        end_test();
    endtask

    task automatic test_in_order();
        rob_idx_t ids [4];
        int base;
        start_test("in_order");
        base = commit_total;
        for (int i = 0; i < 4; i++) begin
            dispatch(1'b1, arch_reg_t'(i + 1), phys_reg_t'(i + 32), phys_reg_t'(i + 1), ids[i]);
            check_idx("disp_rob_idx_o", rob_idx_t'(i), ids[i]);
        end
        // youngest first, commits must still come oldest first
        for (int i = 3; i >= 0; i--) begin
            writeback(ids[i], rob_data_t'(32'ha000_0000 + i));
        end
        wait_commits(base + 4);
        end_test();
    endtask

    task automatic test_full();
        rob_idx_t first;
        rob_idx_t tmp;
        int base;
        start_test("full");
        first = exp_tail;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            dispatch(1'b1, arch_reg_t'(i), phys_reg_t'(i), phys_reg_t'(i + 16), tmp);
        end
        check_flag("disp_ready_o", 1'b0, disp_ready_o);
        check_cnt("disp_space_o", '0, disp_space_o);
        // refused while full
        disp_valid_i = 1'b1;
        cycle();
        disp_valid_i = 1'b0;
        check_flag("disp_alloc_o", 1'b0, alloc_seen);
        base = commit_total;
        writeback(first, 32'h5a5a_0001);
        wait_commits(base + 1);
        check_cnt("disp_space_o", rob_cnt_t'(1), disp_space_o);
        // tail has come all the way round to the first slot
        dispatch(1'b0, '0, '0, '0, tmp);
        check_idx("disp_rob_idx_o", first, tmp);
        drain();
        end_test();
    endtask

    task automatic test_squash();
        rob_idx_t   ids [6];
        rob_idx_t   tmp;
        phys_mask_t exp_free;
        rob_cnt_t   space_before;
        int         base;
        start_test("squash");
        base = commit_total;
        // slots 1 and 4 have no destination
        for (int i = 0; i < 6; i++) begin
            dispatch(i != 1 && i != 4, arch_reg_t'(i + 8), phys_reg_t'(i + 40),
                     phys_reg_t'(i + 10), ids[i]);
        end
        space_before = rob_cnt_t'(`ROB_DEPTH - model_q.size());
        check_cnt("disp_space_o", space_before, disp_space_o);
        mispredict(ids[2], exp_free);
        check_flag("free_valid_o", 1'b1, free_valid_o);
        check_mask("free_regs_o", exp_free, free_regs_o);
        check_cnt("disp_space_o", rob_cnt_t'(space_before + 3), disp_space_o);
        dispatch(1'b1, 5'd7, 6'd50, 6'd7, tmp);
        check_idx("disp_rob_idx_o", rob_idx_t'(ids[2] + 1), tmp);
        drain();
        // three survivors plus the new entry
        check_cnt("commits", rob_cnt_t'(4), rob_cnt_t'(commit_total - base));
        end_test();
    endtask

    task automatic test_random();
        rob_entry_t e;
        rob_data_t  v;
        int k;
        int wraps;
        start_test("random");
        wraps = 0;
        for (int c = 0; c < 400; c++) begin
            disp_valid_i   = 1'($urandom());
            disp_rd_wen_i  = 1'($urandom());
            disp_rd_arch_i = arch_reg_t'($urandom());
            disp_new_prf_i = phys_reg_t'($urandom());
            disp_old_prf_i = phys_reg_t'($urandom());
            wb_valid_i     = 1'b0;
            // pick any live entry, skip it if already written back
            if (model_q.size() > 0 && 1'($urandom()) == 1'b1) begin
                k = int'($urandom() % 32'(model_q.size()));
                e = model_q[k];
                if (!e.done) begin
                    v = rob_data_t'($urandom());
                    e.done  = 1'b1;
                    e.value = v;
                    model_q[k]   = e;
                    wb_valid_i   = 1'b1;
                    wb_rob_idx_i = idx_q[k];
                    wb_value_i   = v;
                end
            end
            cycle();
            if (alloc_seen && idx_seen == '0) begin
                wraps++;
            end
        end
        disp_valid_i = 1'b0;
        wb_valid_i   = 1'b0;
        drain();
        if (wraps < 2) begin
            errors++;
            $display("random stream wrapped the index only %0d times", wraps);
        end
        end_test();
    endtask

    initial begin
        int seed_val;
        seed_val             = $urandom(32'hc6c9_f009);
        reset                = 1'b1;
        disp_valid_i         = 1'b0;
        disp_rd_wen_i        = 1'b0;
        disp_rd_arch_i       = '0;
        disp_new_prf_i       = '0;
        disp_old_prf_i       = '0;
        wb_valid_i           = 1'b0;
        wb_rob_idx_i         = '0;
        wb_value_i           = '0;
        mispredict_i         = 1'b0;
        mispredict_rob_idx_i = '0;
        exp_tail             = '0;
        errors               = 0;
        tests_run            = 0;
        commit_total         = 0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset();
        test_in_order();
        test_full();
        test_squash();
        test_random();
        $display("%0d tests, %0d commits, %0d errors", tests_run, commit_total, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
